//--- common/ddrPkg.sv
package ddrPkg;

  // ========================================
  // bus and array geometry
  // ========================================
  localparam int adrWidth     = 17;
  localparam int dqWidth      = 64;
  localparam int devWidth     = 16;
  localparam int numDevices   = dqWidth / devWidth;

  // bank group bit on top of the two bank address bits
  localparam int bankBits     = 3;
  localparam int numBanks     = 2 ** bankBits;

  // row at ACT and column at RD/WR, both from the low address bits
  localparam int rowBits      = 4;
  localparam int colBits      = 4;
  localparam int wordAddrBits = bankBits + rowBits + colBits;

  // sampled RD edge to dqValid
  localparam int readLatency  = 4;

  // A10 on PRE closes every bank
  localparam int precAllBit   = 10;

  // ========================================
  // command and access encodings
  // ========================================
  // low three bits follow the RAS/CAS/WE code on A16..A14
  typedef enum logic [3:0] {
    cmdMrs  = 4'd0,
    cmdRef  = 4'd1,
    cmdPre  = 4'd2,
    cmdAct  = 4'd3,
    cmdWr   = 4'd4,
    cmdRd   = 4'd5,
    cmdZqc  = 4'd6,
    cmdNop  = 4'd7,
    cmdDsel = 4'd8
  } ddrCmdT;

  typedef enum logic [1:0] {
    opIdle  = 2'd0,
    opRead  = 2'd1,
    opWrite = 2'd2
  } accessOpT;

endpackage

//--- common/ddrAccessIf.sv
interface ddrAccessIf;

  // one access per cycle where op is not idle and no handshake
  ddrPkg::accessOpT                  op;
  logic [ddrPkg::wordAddrBits-1:0]   wordAddr;

  // each device picks its own slice of the full bus
  logic [ddrPkg::dqWidth-1:0]        wrData;

  // decoder side
  modport issuer (
    output op,
    output wordAddr,
    output wrData
  );

  // x16 device side
  modport device (
    input op,
    input wordAddr,
    input wrData
  );

endinterface

//--- rtl/ddrCmdDecoder.sv
module ddrCmdDecoder (
  input  logic                         c0_ddr4_ck_t,
  input  logic                         rstN,
  input  logic                         csN,
  input  logic                         actN,
  input  logic [ddrPkg::adrWidth-1:0]  adr,
  input  logic [1:0]                   ba,
  input  logic [0:0]                   bg,
  input  logic [ddrPkg::dqWidth-1:0]   dqIn,
  output logic                         cmdError,
  ddrAccessIf.issuer                   access
);

  ddrPkg::ddrCmdT                   cmd;
  ddrPkg::accessOpT                 issueOp;
  logic                             reservedCode;
  logic                             illegal;
  logic [ddrPkg::bankBits-1:0]      bank;
  logic [ddrPkg::numBanks-1:0]      bankOpen;
  logic [ddrPkg::rowBits-1:0]       openRow [ddrPkg::numBanks];

  assign bank = {bg, ba};

  // ========================================
  // command decode
  // ========================================
  always_comb begin
    reservedCode = 1'b0;
    if (csN) begin
      cmd = ddrPkg::cmdDsel;
    end else if (!actN) begin
      cmd = ddrPkg::cmdAct;
    end else begin
      case (adr[ddrPkg::adrWidth-1 -: 3])
        3'b000:  cmd = ddrPkg::cmdMrs;
        3'b001:  cmd = ddrPkg::cmdRef;
        3'b010:  cmd = ddrPkg::cmdPre;
        3'b100:  cmd = ddrPkg::cmdWr;
        3'b101:  cmd = ddrPkg::cmdRd;
        3'b110:  cmd = ddrPkg::cmdZqc;
        3'b111:  cmd = ddrPkg::cmdNop;
        default: begin
          // 011 with ACT_n high is reserved
          cmd = ddrPkg::cmdNop;
          reservedCode = 1'b1;
        end
      endcase
    end
  end

  // legality against bank state, and what goes to the devices
  always_comb begin
    illegal = reservedCode;
    issueOp = ddrPkg::opIdle;
    case (cmd)
      ddrPkg::cmdAct: begin
        illegal = bankOpen[bank];
      end
      ddrPkg::cmdRef: begin
        illegal = |bankOpen;
      end
      ddrPkg::cmdWr, ddrPkg::cmdRd: begin
        if (!bankOpen[bank]) begin
          illegal = 1'b1;
        end else if (cmd == ddrPkg::cmdWr) begin
          issueOp = ddrPkg::opWrite;
        end else begin
          issueOp = ddrPkg::opRead;
        end
      end
      default: begin
      end
    endcase
  end

  // ========================================
  // bank state and error flag
  // ========================================
  always_ff @(posedge c0_ddr4_ck_t) begin
    if (!rstN) begin
      bankOpen  <= '0;
      cmdError  <= 1'b0;
      access.op <= ddrPkg::opIdle;
    end else begin
      access.op <= issueOp;
      if (illegal) begin
        cmdError <= 1'b1;
      end
      if (cmd == ddrPkg::cmdAct) begin
        bankOpen[bank] <= 1'b1;
      end else if (cmd == ddrPkg::cmdPre) begin
        if (adr[ddrPkg::precAllBit]) begin
          bankOpen <= '0;
        end else begin
          bankOpen[bank] <= 1'b0;
        end
      end
    end
  end

  // open rows and access payload
  always_ff @(posedge c0_ddr4_ck_t) begin
    if (cmd == ddrPkg::cmdAct) begin
      openRow[bank] <= adr[ddrPkg::rowBits-1:0];
    end
    access.wordAddr <= {bank, openRow[bank], adr[ddrPkg::colBits-1:0]};
    access.wrData   <= dqIn;
  end

endmodule

//--- ddrDevice/ddrDevice.sv
module ddrDevice #(
  parameter int sliceIndex = 0
) (
  input  logic                         c0_ddr4_ck_t,
  input  logic                         rstN,
  ddrAccessIf.device                   access,
  output logic [ddrPkg::devWidth-1:0]  rdSlice,
  output logic                         rdValid
);

  // one x16 word per bank/row/column
  logic [ddrPkg::devWidth-1:0] mem [2 ** ddrPkg::wordAddrBits];
  logic [ddrPkg::devWidth-1:0] wrSlice;

  assign wrSlice = access.wrData[sliceIndex*ddrPkg::devWidth +: ddrPkg::devWidth];

  // ========================================
  // storage array
  // ========================================
  always_ff @(posedge c0_ddr4_ck_t) begin
    if (access.op == ddrPkg::opWrite) begin
      mem[access.wordAddr] <= wrSlice;
    end
    if (access.op == ddrPkg::opRead) begin
      rdSlice <= mem[access.wordAddr];
    end
  end

  // single cycle strobe per read
  always_ff @(posedge c0_ddr4_ck_t) begin
    if (!rstN) begin
      rdValid <= 1'b0;
    end else begin
      rdValid <= (access.op == ddrPkg::opRead);
    end
  end

endmodule

//--- rtl/ddrReadMerge.sv
module ddrReadMerge (
  input  logic                                               c0_ddr4_ck_t,
  input  logic                                               rstN,
  input  logic [ddrPkg::numDevices-1:0][ddrPkg::devWidth-1:0] rdSlices,
  input  logic [ddrPkg::numDevices-1:0]                      rdValids,
  output logic [ddrPkg::dqWidth-1:0]                         dqOut,
  output logic                                               dqValid
);

  // decoder and device already account for two cycles
  logic [ddrPkg::dqWidth-1:0]      dataPipe  [ddrPkg::readLatency-2];
  logic [ddrPkg::readLatency-3:0]  validPipe;

  // ========================================
  // latency pipeline
  // ========================================
  always_ff @(posedge c0_ddr4_ck_t) begin
    if (!rstN) begin
      validPipe <= '0;
    end else begin
      // all devices see the same access, so device 0 speaks for the rank
      validPipe[0] <= rdValids[0];
      for (int i = 1; i < ddrPkg::readLatency - 2; i++) begin
        validPipe[i] <= validPipe[i-1];
      end
    end
  end

  // device 0 lands in the low bits
  always_ff @(posedge c0_ddr4_ck_t) begin
    dataPipe[0] <= rdSlices;
    for (int i = 1; i < ddrPkg::readLatency - 2; i++) begin
      dataPipe[i] <= dataPipe[i-1];
    end
  end

  assign dqOut   = dataPipe[ddrPkg::readLatency-3];
  assign dqValid = validPipe[ddrPkg::readLatency-3];

endmodule

//--- rtl/ddrRankTop.sv
module ddrRankTop (
  input  logic                         c0_ddr4_ck_t,
  input  logic                         rstN,
  input  logic                         csN,
  input  logic                         actN,
  input  logic [ddrPkg::adrWidth-1:0]  adr,
  input  logic [1:0]                   ba,
  input  logic [0:0]                   bg,
  input  logic [ddrPkg::dqWidth-1:0]   dqIn,
  output logic [ddrPkg::dqWidth-1:0]   dqOut,
  output logic                         dqValid,
  output logic                         cmdError
);

  ddrAccessIf accessIf ();

  logic [ddrPkg::numDevices-1:0][ddrPkg::devWidth-1:0] rdSlices;
  logic [ddrPkg::numDevices-1:0]                      rdValids;

  // ========================================
  // shared command path
  // ========================================
  ddrCmdDecoder decoder_i (
    .c0_ddr4_ck_t (c0_ddr4_ck_t),
    .rstN         (rstN),
    .csN          (csN),
    .actN         (actN),
    .adr          (adr),
    .ba           (ba),
    .bg           (bg),
    .dqIn         (dqIn),
    .cmdError     (cmdError),
    .access       (accessIf.issuer)
  );

  // four x16 parts make up the 64-bit rank
  for (genvar g = 0; g < ddrPkg::numDevices; g++) begin : genDevice
    ddrDevice #(
      .sliceIndex (g)
    ) device_i (
      .c0_ddr4_ck_t (c0_ddr4_ck_t),
      .rstN         (rstN),
      .access       (accessIf.device),
      .rdSlice      (rdSlices[g]),
      .rdValid      (rdValids[g])
    );
  end

  ddrReadMerge merge_i (
    .c0_ddr4_ck_t (c0_ddr4_ck_t),
    .rstN         (rstN),
    .rdSlices     (rdSlices),
    .rdValids     (rdValids),
    .dqOut        (dqOut),
    .dqValid      (dqValid)
  );

endmodule

//--- sim/ddrClockGen.sv
module ddrClockGen (
  output logic c0_ddr4_ck_t,
  output logic rstN
);

  timeunit 1ns;
  timeprecision 1ps;

  // 100 ns period
  initial begin
    c0_ddr4_ck_t = 1'b0;
    forever #50 c0_ddr4_ck_t = ~c0_ddr4_ck_t;
  end

  // low across two rising edges and released on a falling edge
  initial begin
    rstN = 1'b0;
    repeat (2) @(posedge c0_ddr4_ck_t);
    @(negedge c0_ddr4_ck_t);
    rstN = 1'b1;
  end

endmodule

//--- sim/ddrRankTb.sv
module ddrRankTb;

  timeunit 1ns;
  timeprecision 1ps;

  logic                         c0_ddr4_ck_t;
  logic                         genRstN;
  logic                         tbRstN;
  logic                         rstN;
  logic                         csN;
  logic                         actN;
  logic [ddrPkg::adrWidth-1:0]  adr;
  logic [1:0]                   ba;
  logic [0:0]                   bg;
  logic [ddrPkg::dqWidth-1:0]   dqIn;
  logic [ddrPkg::dqWidth-1:0]   dqOut;
  logic                         dqValid;
  logic                         cmdError;

  // reference state
  logic [7:0]   refOpen = '0;
  logic [3:0]   refRow [8];
  logic [63:0]  refMem [int];
  logic         refError = 1'b0;

  // reads still owed by the DUT
  logic [63:0]  expData [$];
  int           expEdge [$];

  string        testName = "init";
  int           edgeCount = 0;
  int           errorCount = 0;
  int           checkCount = 0;
  int           testCount = 0;
  int           testErrors = 0;
  logic [31:0]  rngState = 32'd48324;

  // stimulus adds a mid-run reset on top of the power-up one
  assign rstN = genRstN & tbRstN;

  ddrClockGen clkGen_i (
    .c0_ddr4_ck_t (c0_ddr4_ck_t),
    .rstN         (genRstN)
  );

  ddrRankTop dut_i (
    .c0_ddr4_ck_t (c0_ddr4_ck_t),
    .rstN         (rstN),
    .csN          (csN),
    .actN         (actN),
    .adr          (adr),
    .ba           (ba),
    .bg           (bg),
    .dqIn         (dqIn),
    .dqOut        (dqOut),
    .dqValid      (dqValid),
    .cmdError     (cmdError)
  );

  always @(posedge c0_ddr4_ck_t) begin
    edgeCount <= edgeCount + 1;
  end

  // ========================================
  // helpers
  // ========================================
  function automatic logic [31:0] nextRandom();
    rngState = rngState ^ (rngState << 13);
    rngState = rngState ^ (rngState >> 17);
    rngState = rngState ^ (rngState << 5);
    return rngState;
  endfunction

  function automatic logic [63:0] randomWord();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = nextRandom();
    lo = nextRandom();
    return {hi, lo};
  endfunction

  // RAS/CAS/WE code on A16..A14
  function automatic logic [2:0] cmdCode(input ddrPkg::ddrCmdT kind);
    case (kind)
      ddrPkg::cmdMrs: return 3'b000;
      ddrPkg::cmdRef: return 3'b001;
      ddrPkg::cmdPre: return 3'b010;
      ddrPkg::cmdWr:  return 3'b100;
      ddrPkg::cmdRd:  return 3'b101;
      ddrPkg::cmdZqc: return 3'b110;
      default:        return 3'b111;
    endcase
  endfunction

  // reference model returns 1 when a read must come back
  function automatic bit modelCommand(input ddrPkg::ddrCmdT kind, input logic sel,
                                      input logic [2:0] bank, input logic [16:0] a,
                                      input logic [63:0] data, output logic [63:0] rdData);
    int wordAddr;
    rdData = 'x;
    if (!sel) begin
      return 1'b0;
    end
    wordAddr = {bank, refRow[bank], a[3:0]};
    case (kind)
      ddrPkg::cmdAct: begin
        if (refOpen[bank]) begin
          refError = 1'b1;
        end
        refOpen[bank] = 1'b1;
        refRow[bank]  = a[3:0];
      end
      ddrPkg::cmdPre: begin
        if (a[10]) begin
          refOpen = '0;
        end else begin
          refOpen[bank] = 1'b0;
        end
      end
      ddrPkg::cmdRef: begin
        if (|refOpen) begin
          refError = 1'b1;
        end
      end
      ddrPkg::cmdWr, ddrPkg::cmdRd: begin
        if (!refOpen[bank]) begin
          refError = 1'b1;
        end else if (kind == ddrPkg::cmdWr) begin
          refMem[wordAddr] = data;
        end else begin
          // never written means the array still holds X
          if (refMem.exists(wordAddr)) begin
            rdData = refMem[wordAddr];
          end
          return 1'b1;
        end
      end
      default: begin
      end
    endcase
    return 1'b0;
  endfunction

  task automatic checkBit(input string what, input logic expected, input logic actual);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("Error %s %s expected %b actual %b", testName, what, expected, actual);
    end
  endtask

  // drives one command on a falling edge and holds it for one cycle
  task automatic issueCommand(input ddrPkg::ddrCmdT kind, input logic [2:0] bank,
                              input logic [16:0] lowAdr, input logic [63:0] data,
                              input logic sel = 1'b1);
    logic [63:0] rdData;
    bit          hasRead;
    csN  = !sel;
    actN = (kind == ddrPkg::cmdAct) ? 1'b0 : 1'b1;
    adr  = lowAdr;
    if (kind != ddrPkg::cmdAct) begin
      adr[16:14] = cmdCode(kind);
    end
    {bg, ba} = bank;
    dqIn     = data;
    hasRead  = modelCommand(kind, sel, bank, adr, data, rdData);
    if (hasRead) begin
      expData.push_back(rdData);
      expEdge.push_back(edgeCount + 1 + ddrPkg::readLatency);
    end
    @(negedge c0_ddr4_ck_t);
    checkBit("cmdError", refError, cmdError);
    csN  = 1'b1;
    actN = 1'b1;
  endtask

  task automatic waitDrain(input int limit);
    int cycles;
    cycles = 0;
    while (expData.size() > 0 && cycles < limit) begin
      @(posedge c0_ddr4_ck_t);
      cycles++;
    end
    if (expData.size() > 0) begin
      errorCount++;
      $display("test %s: read data still outstanding after %0d cycles", testName, limit);
      expData.delete();
      expEdge.delete();
    end
    @(negedge c0_ddr4_ck_t);
  endtask

  task automatic applyReset();
    csN    = 1'b1;
    actN   = 1'b1;
    tbRstN = 1'b0;
    repeat (2) @(negedge c0_ddr4_ck_t);
    tbRstN   = 1'b1;
    refOpen  = '0;
    refError = 1'b0;
  endtask

  task automatic startTest(input string name);
    testName   = name;
    testErrors = errorCount;
    testCount++;
  endtask

  task automatic finishTest();
    waitDrain(20);
    if (errorCount == testErrors) begin
      $display("test %s: ok", testName);
    end else begin
      $display("test %s: %0d errors", testName, errorCount - testErrors);
    end
  endtask

  // ========================================
  // read comparison
  // ========================================
  // sampled a little after the falling edge away from the drive
  always begin
    @(negedge c0_ddr4_ck_t);
    #10;
    if (dqValid === 1'b1) begin
      if (expData.size() == 0) begin
        errorCount++;
        $display("test %s: dqValid rose with no read outstanding", testName);
      end else begin
        checkCount++;
        if (expEdge[0] != edgeCount + 1) begin
          errorCount++;
          $display("Error %s read edge expected %0d actual %0d",
                   testName, expEdge[0], edgeCount + 1);
        end
        if (dqOut !== expData[0]) begin
          errorCount++;
          $display("Error %s dqOut expected %h actual %h", testName, expData[0], dqOut);
        end
        void'(expData.pop_front());
        void'(expEdge.pop_front());
      end
    end else if (expEdge.size() > 0 && edgeCount + 1 >= expEdge[0]) begin
      errorCount++;
      $display("test %s: dqValid missing for an expected read", testName);
      void'(expData.pop_front());
      void'(expEdge.pop_front());
    end
  end

  // ========================================
  // stimulus
  // ========================================
  initial begin
    logic [31:0] r;
    logic [2:0]  bank;
    logic [63:0] word;
    logic [63:0] oldWord;
    int          cycles;

    csN    = 1'b1;
    actN   = 1'b1;
    adr    = '0;
    ba     = '0;
    bg     = '0;
    dqIn   = '0;
    tbRstN = 1'b1;

    cycles = 0;
    while (genRstN !== 1'b1 && cycles < 10) begin
      @(posedge c0_ddr4_ck_t);
      cycles++;
    end
    if (genRstN !== 1'b1) begin
      errorCount++;
      $display("power-up reset was never released");
    end
    @(negedge c0_ddr4_ck_t);

    startTest("writeRead");
    word = randomWord();
    issueCommand(ddrPkg::cmdAct, 3'd2, 17'h5, '0);
    issueCommand(ddrPkg::cmdWr, 3'd2, 17'h9, word);
    issueCommand(ddrPkg::cmdRd, 3'd2, 17'h9, '0);
    finishTest();

    // few rows and columns so reads mostly hit written words
    startTest("randomTraffic");
    for (int i = 0; i < 80; i++) begin
      r    = nextRandom();
      bank = r[2:0];
      if (!refOpen[bank]) begin
        issueCommand(ddrPkg::cmdAct, bank, {16'd0, r[4]}, '0);
      end else begin
        case (r[9:8])
          2'd0: issueCommand(ddrPkg::cmdWr, bank, {15'd0, r[11:10]}, randomWord());
          2'd3: issueCommand(ddrPkg::cmdPre, bank, {6'd0, r[14] & r[15], 10'd0}, '0);
          default: issueCommand(ddrPkg::cmdRd, bank, {15'd0, r[11:10]}, '0);
        endcase
      end
    end
    checkBit("cmdError", 1'b0, cmdError);
    finishTest();

    startTest("backToBack");
    issueCommand(ddrPkg::cmdPre, 3'd0, 17'h400, '0);
    issueCommand(ddrPkg::cmdAct, 3'd5, 17'h3, '0);
    for (int c = 0; c < 4; c++) begin
      issueCommand(ddrPkg::cmdWr, 3'd5, 17'(c), randomWord());
    end
    for (int c = 0; c < 4; c++) begin
      issueCommand(ddrPkg::cmdRd, 3'd5, 17'(c), '0);
    end
    finishTest();

    startTest("deselect");
    oldWord = randomWord();
    word    = ~oldWord;
    issueCommand(ddrPkg::cmdWr, 3'd5, 17'h7, oldWord);
    issueCommand(ddrPkg::cmdWr, 3'd5, 17'h7, word, 1'b0);
    issueCommand(ddrPkg::cmdRd, 3'd5, 17'h7, '0);
    finishTest();

    startTest("closedBank");
    // bank 1 open and error flag raised ahead of the reset
    issueCommand(ddrPkg::cmdAct, 3'd1, 17'h2, '0);
    issueCommand(ddrPkg::cmdAct, 3'd1, 17'h3, '0);
    applyReset();
    checkBit("cmdError after reset", 1'b0, cmdError);
    issueCommand(ddrPkg::cmdRd, 3'd1, 17'h2, '0);
    // any dqValid in this window is caught by the comparison
    repeat (8) @(negedge c0_ddr4_ck_t);
    checkBit("cmdError", 1'b1, cmdError);
    finishTest();

    startTest("prechargeAll");
    issueCommand(ddrPkg::cmdAct, 3'd4, 17'h1, '0);
    issueCommand(ddrPkg::cmdPre, 3'd0, 17'h400, '0);
    issueCommand(ddrPkg::cmdRd, 3'd4, 17'h6, '0);
    repeat (8) @(negedge c0_ddr4_ck_t);
    checkBit("cmdError", 1'b1, cmdError);
    finishTest();

    $display("tests %0d  checks %0d  errors %0d", testCount, checkCount, errorCount);
    if (errorCount == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

//--- list.f
common/ddrPkg.sv
common/ddrAccessIf.sv
rtl/ddrCmdDecoder.sv
ddrDevice/ddrDevice.sv
rtl/ddrReadMerge.sv
rtl/ddrRankTop.sv
sim/ddrClockGen.sv
sim/ddrRankTb.sv

//--- Bender.yml
package:
  name: ddrRank

sources:
  # shared package and interface
  - common/ddrPkg.sv
  - common/ddrAccessIf.sv

  # rank model
  - rtl/ddrCmdDecoder.sv
  - ddrDevice/ddrDevice.sv
  - rtl/ddrReadMerge.sv
  - rtl/ddrRankTop.sv

  # testbench
  - target: simulation
    files:
      - sim/ddrClockGen.sv
      - sim/ddrRankTb.sv
